// ==== Bender.yml ====
package:
  name: knight_core

sources:
  - logic/knight_pkg.sv
  - logic/knight_cmd_proc.sv
  - logic/heading_ctrl.sv
  - logic/position_track.sv
  - logic/fanfare_gen.sv
  - logic/knight_top.sv
  - target: test
    files:
      - tests/knight_checker.sv
      - tests/knight_tb.sv

// ==== compile.f ====
logic/knight_pkg.sv
logic/knight_cmd_proc.sv
logic/heading_ctrl.sv
logic/position_track.sv
logic/fanfare_gen.sv
logic/knight_top.sv
tests/knight_checker.sv
tests/knight_tb.sv

// ==== logic/fanfare_gen.sv ====
`timescale 1ns/1ps

module fanfare_gen #(
  parameter int NOTE_CYCLES = 128
) (
  input  logic clk,
  input  logic reset,
  input  logic fanfare_start,
  output logic piezo,
  output logic piezo_n,
  output logic fanfare_done
);

  // Long notes get proportionally longer tone periods so they stay audible
  localparam int TONE_BASE = (NOTE_CYCLES > 2048) ? (NOTE_CYCLES / 2048) : 1;
  localparam int NOTE_W    = $clog2(NOTE_CYCLES);
  localparam int TONE_W    = $clog2(TONE_BASE * 12 + 1);

  logic              playing;
  logic [1:0]        note_idx;
  logic [NOTE_W-1:0] note_cnt;
  logic [TONE_W-1:0] tone_cnt;
  logic [TONE_W-1:0] tone_half;
  logic              note_end;

  // Half periods of the four rising notes
  function automatic logic [TONE_W-1:0] half_period(input logic [1:0] idx);
    logic [TONE_W-1:0] result;
    case (idx)
      2'd0:    result = TONE_W'(TONE_BASE * 12);
      2'd1:    result = TONE_W'(TONE_BASE * 9);
      2'd2:    result = TONE_W'(TONE_BASE * 7);
      default: result = TONE_W'(TONE_BASE * 6);
    endcase
    return result;
  endfunction

  assign tone_half = half_period(note_idx);
  assign note_end  = (note_cnt == NOTE_W'(NOTE_CYCLES - 1));

  // The piezo is driven differentially
  assign piezo_n = ~piezo;

  ////////////////////////////////////////////////////////////
  // Note sequencer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      playing      <= 1'b0;
      note_idx     <= '0;
      note_cnt     <= '0;
      tone_cnt     <= '0;
      piezo        <= 1'b0;
      fanfare_done <= 1'b0;
    end else begin
      fanfare_done <= 1'b0;
      if (fanfare_start) begin
        playing  <= 1'b1;
        note_idx <= '0;
        note_cnt <= '0;
        tone_cnt <= '0;
        piezo    <= 1'b0;
      end else if (playing) begin
        if (note_end) begin
          note_cnt <= '0;
          tone_cnt <= '0;
          if (note_idx == 2'd3) begin
            // Last note over so go quiet and tell the controller
            playing      <= 1'b0;
            piezo        <= 1'b0;
            fanfare_done <= 1'b1;
          end else begin
            note_idx <= note_idx + 1'b1;
          end
        end else begin
          note_cnt <= note_cnt + 1'b1;
          if (tone_cnt == tone_half - 1'b1) begin
            tone_cnt <= '0;
            piezo    <= ~piezo;
          end else begin
            tone_cnt <= tone_cnt + 1'b1;
          end
        end
      end
    end
  end

endmodule

// ==== logic/heading_ctrl.sv ====
`timescale 1ns/1ps

module heading_ctrl import knight_pkg::*; #(
  parameter int HEAD_STEP = 16
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              head_load,
  input  logic [HEAD_W-1:0] target_heading,
  output logic [HEAD_W-1:0] heading,
  output logic              head_settled
);

  localparam logic [HEAD_W-1:0] STEP      = HEAD_W'(HEAD_STEP);
  localparam logic [HEAD_W-1:0] HALF_TURN = {1'b1, {(HEAD_W - 1){1'b0}}};

  logic [HEAD_W-1:0] target;
  logic [HEAD_W-1:0] diff;
  logic [HEAD_W-1:0] diff_mag;
  logic [HEAD_W-1:0] heading_nxt;
  logic              turn_neg;
  dir_e              target_dir;

  ////////////////////////////////////////////////////////////
  // Shorter arc
  ////////////////////////////////////////////////////////////

  // The wrapped difference read as signed gives the shorter arc
  assign diff     = target - heading;
  assign diff_mag = diff[HEAD_W-1] ? -diff : diff;

  // Quadrant of the target from its heading field
  assign target_dir = heading_dir(target[HEAD_W-1 -: 8]);

  always_comb begin
    // A half turn has no shorter side
    // Clockwise toward E or N and the other way toward W or S
    // so that reversing a turn retraces the same arc
    if (diff == HALF_TURN) begin
      turn_neg = (target_dir == DIR_E) || (target_dir == DIR_N);
    end else begin
      turn_neg = diff[HEAD_W-1];
    end

    // Land on the target when it is within one step
    if (diff_mag <= STEP) begin
      heading_nxt = target;
    end else if (turn_neg) begin
      heading_nxt = heading - STEP;
    end else begin
      heading_nxt = heading + STEP;
    end
  end

  assign head_settled = (heading == target);

  ////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      target  <= '0;
      heading <= '0;
    end else begin
      if (head_load) begin
        target <= target_heading;
      end
      heading <= heading_nxt;
    end
  end

endmodule

// ==== logic/knight_cmd_proc.sv ====
`timescale 1ns/1ps

module knight_cmd_proc import knight_pkg::*; #(
  parameter int CAL_CYCLES = 256
) (
  input  logic              clk,
  input  logic              reset,
  input  logic [CMD_W-1:0]  cmd,
  input  logic              cmd_valid,
  output logic              cmd_ready,
  output logic [7:0]        resp,
  output logic              resp_valid,
  input  logic              resp_ready,
  input  logic              line_pulse,
  output logic              moving,
  output logic              cal_done,
  output logic              head_load,
  output logic [HEAD_W-1:0] target_heading,
  input  logic              head_settled,
  output logic              square_step,
  output logic              pos_load,
  output knight_cmd_u       cmd_word,
  output logic              fanfare_start,
  input  logic              fanfare_done
);

  // Wide enough to hold CAL_CYCLES - 1
  localparam int CAL_W = $clog2(CAL_CYCLES + 1);

  localparam logic [2:0] ST_IDLE    = 3'd0;
  localparam logic [2:0] ST_CAL     = 3'd1;
  localparam logic [2:0] ST_TURN    = 3'd2;
  localparam logic [2:0] ST_DRIVE   = 3'd3;
  localparam logic [2:0] ST_FANFARE = 3'd4;
  localparam logic [2:0] ST_RESP    = 3'd5;

  logic [2:0]       state;
  logic [CAL_W-1:0] cal_cnt;
  logic [3:0]       squares_left;
  knight_cmd_u      cmd_in;
  logic             accept;
  logic             op_is_move;
  logic             op_is_known;

  ////////////////////////////////////////////////////////////
  // Command decode
  ////////////////////////////////////////////////////////////

  assign cmd_in = cmd;

  // Commands are taken only from IDLE so a pending response holds off the host
  assign cmd_ready = (state == ST_IDLE);
  assign accept    = cmd_valid && cmd_ready;

  // Each opcode is checked against the view it belongs to
  assign op_is_move  = (cmd_in.move.op == OP_MOVE) || (cmd_in.move.op == OP_MOVE_FANFARE);
  assign op_is_known = op_is_move || (cmd_in.move.op == OP_CAL) ||
                       (cmd_in.pos.op == OP_SET_POS);

  // A zero heading field means due north and gets no low fill
  assign target_heading = (cmd_word.move.heading == 8'h00) ? '0 :
                          {cmd_word.move.heading, 4'hF};

  // The floor sensor is listened to only while driving
  assign moving = (state == ST_DRIVE);

  // Pulses past the last square of the move are dropped
  assign square_step = moving && line_pulse && (squares_left != '0);

  // Captured word and response byte
  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_word <= cmd_in;
      resp     <= op_is_known ? RESP_ACK : RESP_NACK;
    end
  end

  ////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state         <= ST_IDLE;
      cal_cnt       <= '0;
      squares_left  <= '0;
      resp_valid    <= 1'b0;
      cal_done      <= 1'b0;
      head_load     <= 1'b0;
      pos_load      <= 1'b0;
      fanfare_start <= 1'b0;
    end else begin
      // Strobes last a single cycle
      head_load     <= 1'b0;
      pos_load      <= 1'b0;
      fanfare_start <= 1'b0;

      case (state)
        ST_IDLE: begin
          if (accept) begin
            squares_left <= cmd_in.move.squares;
            if (cmd_in.move.op == OP_CAL) begin
              cal_cnt <= CAL_W'(CAL_CYCLES - 1);
              state   <= ST_CAL;
            end else if (op_is_move) begin
              head_load <= 1'b1;
              state     <= ST_TURN;
            end else begin
              // Set-position loads during the cycle before the response
              pos_load <= (cmd_in.pos.op == OP_SET_POS);
              state    <= ST_RESP;
            end
          end
        end

        ST_CAL: begin
          if (cal_cnt == '0) begin
            state <= ST_RESP;
          end else begin
            cal_cnt <= cal_cnt - 1'b1;
          end
        end

        // The settled flag is stale until the new target has been loaded
        ST_TURN: begin
          if (!head_load && head_settled) begin
            state <= ST_DRIVE;
          end
        end

        ST_DRIVE: begin
          if (squares_left == '0) begin
            if (cmd_word.move.op == OP_MOVE_FANFARE) begin
              fanfare_start <= 1'b1;
              state         <= ST_FANFARE;
            end else begin
              state <= ST_RESP;
            end
          end else if (line_pulse) begin
            squares_left <= squares_left - 1'b1;
          end
        end

        ST_FANFARE: begin
          if (fanfare_done) begin
            state <= ST_RESP;
          end
        end

        // First cycle raises valid and later cycles wait for the host
        ST_RESP: begin
          if (!resp_valid) begin
            resp_valid <= 1'b1;
            if (cmd_word.move.op == OP_CAL) begin
              cal_done <= 1'b1;
            end
          end else if (resp_ready) begin
            resp_valid <= 1'b0;
            state      <= ST_IDLE;
          end
        end

        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

// ==== logic/knight_pkg.sv ====
package knight_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  // The host command word is 16 bits wide
  localparam int CMD_W = 16;
  // The heading spans a full circle in 12 bits
  localparam int HEAD_W = 12;
  // One board coordinate covers the eight ranks or files
  localparam int COORD_W = 3;

  ////////////////////////////////////////////////////////////
  // Opcodes and responses
  ////////////////////////////////////////////////////////////

  typedef enum logic [3:0] {
    OP_CAL          = 4'h2,
    OP_MOVE         = 4'h4,
    OP_MOVE_FANFARE = 4'h5,
    OP_SET_POS      = 4'h6
  } op_e;

  // Acknowledge and reject bytes sent back to the host
  localparam logic [7:0] RESP_ACK  = 8'hA5;
  localparam logic [7:0] RESP_NACK = 8'hEE;

  // Compass points in the order of rising heading
  typedef enum logic [1:0] {
    DIR_N = 2'd0,
    DIR_W = 2'd1,
    DIR_S = 2'd2,
    DIR_E = 2'd3
  } dir_e;

  ////////////////////////////////////////////////////////////
  // Command word
  ////////////////////////////////////////////////////////////

  // Move view with the heading field and the number of squares to drive
  typedef struct packed {
    op_e        op;
    logic [7:0] heading;
    logic [3:0] squares;
  } move_cmd_t;

  // Set-position view with the new board coordinates
  typedef struct packed {
    op_e                op;
    logic [4:0]         rsvd_hi;
    logic [COORD_W-1:0] x;
    logic               rsvd_lo;
    logic [COORD_W-1:0] y;
  } pos_cmd_t;

  typedef union packed {
    move_cmd_t move;
    pos_cmd_t  pos;
  } knight_cmd_u;

  // Heading field to compass point
  // Adding an eighth of a turn first rounds 8'h3F, 8'h7F and 8'hBF to W, S and E
  function automatic dir_e heading_dir(input logic [7:0] field);
    logic [7:0] rounded;
    rounded = field + 8'h20;
    return dir_e'(rounded[7:6]);
  endfunction

endpackage

// ==== logic/knight_top.sv ====
`timescale 1ns/1ps

module knight_top import knight_pkg::*; #(
  parameter bit FAST_SIM = 1'b1
) (
  input  logic               clk,
  input  logic               reset,
  input  logic [CMD_W-1:0]   cmd,
  input  logic               cmd_valid,
  output logic               cmd_ready,
  output logic [7:0]         resp,
  output logic               resp_valid,
  input  logic               resp_ready,
  input  logic               line_pulse,
  output logic [HEAD_W-1:0]  heading,
  output logic [COORD_W-1:0] xx,
  output logic [COORD_W-1:0] yy,
  output logic               moving,
  output logic               cal_done,
  output logic               piezo,
  output logic               piezo_n
);

  // Simulation shortens calibration and the notes
  localparam int CAL_CYCLES  = FAST_SIM ? 256 : (1 << 22);
  localparam int NOTE_CYCLES = FAST_SIM ? 128 : (1 << 23);
  // Slew per clock for the turn
  localparam int HEAD_STEP   = 16;

  logic              head_load;
  logic [HEAD_W-1:0] target_heading;
  logic              head_settled;
  logic              square_step;
  logic              pos_load;
  knight_cmd_u       cmd_word;
  logic              fanfare_start;
  logic              fanfare_done;

  ////////////////////////////////////////////////////////////
  // Controller and datapath
  ////////////////////////////////////////////////////////////

  knight_cmd_proc #(
    .CAL_CYCLES(CAL_CYCLES)
  ) cmd_proc0 (
    .clk(clk), .reset(reset),
    .cmd(cmd), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
    .resp(resp), .resp_valid(resp_valid), .resp_ready(resp_ready),
    .line_pulse(line_pulse), .moving(moving), .cal_done(cal_done),
    .head_load(head_load), .target_heading(target_heading), .head_settled(head_settled),
    .square_step(square_step), .pos_load(pos_load), .cmd_word(cmd_word),
    .fanfare_start(fanfare_start), .fanfare_done(fanfare_done)
  );

  heading_ctrl #(
    .HEAD_STEP(HEAD_STEP)
  ) heading0 (
    .clk(clk), .reset(reset),
    .head_load(head_load), .target_heading(target_heading),
    .heading(heading), .head_settled(head_settled)
  );

  position_track position0 (
    .clk(clk), .reset(reset),
    .square_step(square_step), .pos_load(pos_load), .cmd_word(cmd_word),
    .xx(xx), .yy(yy)
  );

  fanfare_gen #(
    .NOTE_CYCLES(NOTE_CYCLES)
  ) fanfare0 (
    .clk(clk), .reset(reset),
    .fanfare_start(fanfare_start),
    .piezo(piezo), .piezo_n(piezo_n), .fanfare_done(fanfare_done)
  );

endmodule

// ==== logic/position_track.sv ====
`timescale 1ns/1ps

module position_track import knight_pkg::*; (
  input  logic               clk,
  input  logic               reset,
  input  logic               square_step,
  input  logic               pos_load,
  input  knight_cmd_u        cmd_word,
  output logic [COORD_W-1:0] xx,
  output logic [COORD_W-1:0] yy
);

  dir_e step_dir;

  // Direction of travel for the move in progress
  assign step_dir = heading_dir(cmd_word.move.heading);

  ////////////////////////////////////////////////////////////
  // Board coordinates
  ////////////////////////////////////////////////////////////

  // Coordinates wrap modulo 8 through the natural counter width
  always_ff @(posedge clk) begin
    if (reset) begin
      xx <= '0;
      yy <= '0;
    end else if (pos_load) begin
      // Set-position takes both coordinates from the word at once
      xx <= cmd_word.pos.x;
      yy <= cmd_word.pos.y;
    end else if (square_step) begin
      case (step_dir)
        // North climbs the ranks
        DIR_N: begin
          yy <= yy + 1'b1;
        end
        // South goes back down
        DIR_S: begin
          yy <= yy - 1'b1;
        end
        // East moves right along the file index
        DIR_E: begin
          xx <= xx + 1'b1;
        end
        // West moves left
        DIR_W: begin
          xx <= xx - 1'b1;
        end
        default: begin
          xx <= xx;
          yy <= yy;
        end
      endcase
    end
  end

endmodule

// ==== tests/knight_checker.sv ====
`timescale 1ns/1ps

module knight_checker import knight_pkg::*; #(
  parameter int CAL_CYCLES = 256
) (
  input  logic               clk,
  input  logic               reset,
  input  logic [CMD_W-1:0]   cmd,
  input  logic               cmd_valid,
  input  logic               cmd_ready,
  input  logic [7:0]         resp,
  input  logic               resp_valid,
  input  logic               resp_ready,
  input  logic [HEAD_W-1:0]  heading,
  input  logic [COORD_W-1:0] xx,
  input  logic [COORD_W-1:0] yy,
  input  logic               moving,
  input  logic               cal_done,
  input  logic               piezo,
  input  logic               piezo_n,
  output int                 test_count,
  output int                 error_count
);

  // Model state kept from the expected results, never from the DUT
  logic [COORD_W-1:0] model_x;
  logic [COORD_W-1:0] model_y;
  logic [HEAD_W-1:0]  model_head;
  logic [CMD_W-1:0]   cur_cmd;
  logic [25:0]        exp_res;
  logic               busy;
  logic               rise_seen;
  logic               last_piezo;
  logic               piezo_bad;
  logic               cmd_is_move;
  logic               drive_seen;
  logic               drive_bad;
  logic               idle_move_bad;
  int                 cyc;
  int                 acc_cyc;
  int                 latency;
  int                 toggles;
  int                 test_errors;
  string              name;

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // Packs {resp, x, y, heading} for one command from the last known state
  function automatic logic [25:0] expect_result(input logic [CMD_W-1:0] c,
                                                input logic [COORD_W-1:0] x,
                                                input logic [COORD_W-1:0] y,
                                                input logic [HEAD_W-1:0] h);
    logic [7:0]         r;
    logic [COORD_W-1:0] nx;
    logic [COORD_W-1:0] ny;
    logic [HEAD_W-1:0]  nh;
    logic [7:0]         field;
    logic [3:0]         n;
    r = RESP_ACK;
    nx = x;
    ny = y;
    nh = h;
    field = c[11:4];
    n = c[3:0];
    case (c[15:12])
      OP_CAL: begin
        nh = h;
      end
      OP_MOVE, OP_MOVE_FANFARE: begin
        // Zero field is due north, anything else gets the low fill
        nh = (field == 8'h00) ? 12'h000 : {field, 4'hF};
        // Sums are cut to three bits, so the board wraps modulo 8
        case (field)
          8'h00: ny = y + n;
          8'h7F: ny = y - n;
          8'hBF: nx = x + n;
          8'h3F: nx = x - n;
          default: nx = x;
        endcase
      end
      OP_SET_POS: begin
        nx = c[6:4];
        ny = c[2:0];
      end
      default: r = RESP_NACK;
    endcase
    return {r, nx, ny, nh};
  endfunction

  function automatic string op_name(input logic [3:0] op);
    case (op)
      OP_CAL:          return "cal";
      OP_MOVE:         return "move";
      OP_MOVE_FANFARE: return "move_fanfare";
      OP_SET_POS:      return "set_pos";
      default:         return "unknown";
    endcase
  endfunction

  task automatic check_value(input string what, input logic [15:0] expv,
                             input logic [15:0] actv);
    if (expv !== actv) begin
      $display("ERROR %s %s expected %0h actual %0h", name, what, expv, actv);
      test_errors++;
    end
  endtask

  // Both move opcodes turn and then drive
  assign cmd_is_move = (cur_cmd[15:12] == OP_MOVE) || (cur_cmd[15:12] == OP_MOVE_FANFARE);

  ////////////////////////////////////////////////////////////
  // Handshake watcher
  ////////////////////////////////////////////////////////////

  // Samples at the rising edge, so every value is the one the DUT sees
  always @(posedge clk) begin
    if (reset) begin
      model_x = '0;
      model_y = '0;
      model_head = '0;
      busy = 1'b0;
      rise_seen = 1'b0;
      last_piezo = 1'b0;
      piezo_bad = 1'b0;
      drive_seen = 1'b0;
      drive_bad = 1'b0;
      idle_move_bad = 1'b0;
      cyc = 0;
      test_count = 0;
      error_count = 0;
    end else begin
      cyc++;
      // Differential drive must hold on every cycle
      if (piezo_n !== ~piezo && !piezo_bad) begin
        $display("piezo_n is not the inverse of piezo at cycle %0d", cyc);
        piezo_bad = 1'b1;
        error_count++;
      end
      if (busy && cmd_ready) begin
        $display("cmd_ready went high before the response of %s transferred", name);
        test_errors++;
      end
      // The sensor window opens only once the turn of a move has settled
      // and closes before the response
      if (moving) begin
        if (!busy) begin
          if (!idle_move_bad) begin
            $display("moving went high with no command in progress at cycle %0d", cyc);
            idle_move_bad = 1'b1;
            error_count++;
          end
        end else if (!cmd_is_move || resp_valid || heading !== exp_res[11:0]) begin
          drive_bad = 1'b1;
        end else begin
          drive_seen = 1'b1;
        end
      end
      if (busy && piezo !== last_piezo) begin
        toggles++;
      end
      last_piezo = piezo;
      // Valid rose on the edge before the one where it is first seen
      if (busy && resp_valid && !rise_seen) begin
        rise_seen = 1'b1;
        latency = cyc - acc_cyc - 1;
      end
      if (cmd_valid && cmd_ready) begin
        busy = 1'b1;
        cur_cmd = cmd;
        acc_cyc = cyc;
        toggles = 0;
        rise_seen = 1'b0;
        drive_seen = 1'b0;
        drive_bad = 1'b0;
        test_errors = 0;
        exp_res = expect_result(cmd, model_x, model_y, model_head);
        name = $sformatf("t%0d_%s", test_count, op_name(cmd[15:12]));
      end else if (busy && resp_valid && resp_ready) begin
        busy = 1'b0;
        check_value("resp", exp_res[25:18], resp);
        check_value("x", exp_res[17:15], xx);
        check_value("y", exp_res[14:12], yy);
        check_value("heading", exp_res[11:0], heading);
        case (cur_cmd[15:12])
          OP_CAL: begin
            check_value("latency", CAL_CYCLES + 1, latency);
            check_value("cal_done", 1'b1, cal_done);
          end
          OP_MOVE, OP_MOVE_FANFARE: begin
          end
          default: check_value("latency", 1, latency);
        endcase
        if (drive_bad) begin
          $display("%s moving was high outside the drive phase of a settled move", name);
          test_errors++;
        end
        if (cmd_is_move && !drive_seen) begin
          $display("%s moving never went high during the move", name);
          test_errors++;
        end
        // The piezo only sings on fanfare moves
        if ((cur_cmd[15:12] == OP_MOVE_FANFARE) != (toggles > 0)) begin
          $display("%s piezo toggled %0d times, wrong for this opcode", name, toggles);
          test_errors++;
        end
        $display("%s %s cmd %h resp %h pos (%0d,%0d) heading %h",
                 (test_errors == 0) ? "PASS" : "FAIL", name, cur_cmd, resp, xx, yy, heading);
        model_x = exp_res[17:15];
        model_y = exp_res[14:12];
        model_head = exp_res[11:0];
        error_count += test_errors;
        test_count++;
      end
    end
  end

endmodule

// ==== tests/knight_tb.sv ====
`timescale 1ns/1ps

module knight_tb import knight_pkg::*; ;

  localparam int WAIT_LIMIT = 4000;

  logic               clk;
  logic               reset;
  logic [CMD_W-1:0]   cmd;
  logic               cmd_valid;
  logic               cmd_ready;
  logic [7:0]         resp;
  logic               resp_valid;
  logic               resp_ready;
  logic               line_pulse;
  logic [HEAD_W-1:0]  heading;
  logic [COORD_W-1:0] xx;
  logic [COORD_W-1:0] yy;
  logic               moving;
  logic               cal_done;
  logic               piezo;
  logic               piezo_n;
  int                 test_count;
  int                 error_count;
  int                 sent;
  logic               timed_out;
  logic [7:0]         dirs [4] = '{8'h00, 8'h3F, 8'h7F, 8'hBF};

  knight_top #(.FAST_SIM(1'b1)) dut0 (
    .clk(clk), .reset(reset),
    .cmd(cmd), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
    .resp(resp), .resp_valid(resp_valid), .resp_ready(resp_ready),
    .line_pulse(line_pulse), .heading(heading), .xx(xx), .yy(yy),
    .moving(moving), .cal_done(cal_done), .piezo(piezo), .piezo_n(piezo_n)
  );

  knight_checker #(.CAL_CYCLES(256)) checker0 (
    .clk(clk), .reset(reset),
    .cmd(cmd), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
    .resp(resp), .resp_valid(resp_valid), .resp_ready(resp_ready),
    .heading(heading), .xx(xx), .yy(yy), .moving(moving), .cal_done(cal_done),
    .piezo(piezo), .piezo_n(piezo_n),
    .test_count(test_count), .error_count(error_count)
  );

  always #2 clk = ~clk;

  // Host back-pressure, changed only on the falling edge
  always @(negedge clk) begin
    if (reset) begin
      resp_ready = 1'b0;
    end else begin
      resp_ready = ($urandom_range(3, 0) != 0);
    end
  end

  ////////////////////////////////////////////////////////////
  // Driver tasks
  ////////////////////////////////////////////////////////////

  // Holds the word until the DUT takes it at a rising edge
  task automatic send_cmd(input logic [CMD_W-1:0] w);
    int n;
    if (timed_out) return;
    @(negedge clk);
    cmd = w;
    cmd_valid = 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!cmd_ready && n < WAIT_LIMIT);
    @(negedge clk);
    cmd_valid = 1'b0;
    if (n >= WAIT_LIMIT) begin
      $display("timeout waiting for cmd_ready");
      timed_out = 1'b1;
    end
    sent++;
  endtask

  // One pulse per square with a random gap before each
  task automatic drive_pulses(input logic [3:0] count);
    int n;
    if (timed_out || count == 0) return;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!moving && n < WAIT_LIMIT);
    if (n >= WAIT_LIMIT) begin
      $display("timeout waiting for moving");
      timed_out = 1'b1;
      return;
    end
    for (int i = 0; i < count; i++) begin
      repeat ($urandom_range(3, 0)) @(negedge clk);
      @(negedge clk);
      line_pulse = 1'b1;
      @(negedge clk);
      line_pulse = 1'b0;
    end
  endtask

  task automatic wait_resp();
    int n;
    if (timed_out) return;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!(resp_valid && resp_ready) && n < WAIT_LIMIT);
    @(negedge clk);
    if (n >= WAIT_LIMIT) begin
      $display("timeout waiting for resp_valid");
      timed_out = 1'b1;
    end
  endtask

  task automatic run_cmd(input logic [CMD_W-1:0] w);
    send_cmd(w);
    if (w[15:12] == OP_MOVE || w[15:12] == OP_MOVE_FANFARE) begin
      drive_pulses(w[3:0]);
    end
    wait_resp();
  endtask

  // A pulse while idle must not move the robot
  task automatic stray_pulse();
    @(negedge clk);
    line_pulse = 1'b1;
    @(negedge clk);
    line_pulse = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    logic [3:0]         op;
    logic [COORD_W-1:0] rx;
    logic [COORD_W-1:0] ry;
    void'($urandom(32'h8cb5));
    clk = 1'b0;
    reset = 1'b1;
    cmd = '0;
    cmd_valid = 1'b0;
    resp_ready = 1'b0;
    line_pulse = 1'b0;
    sent = 0;
    timed_out = 1'b0;
    repeat (4) @(negedge clk);
    reset = 1'b0;

    // Fixed sequence with calibration, the reference moves and wrap-around
    run_cmd(16'h2000);
    run_cmd(16'h4002);
    run_cmd(16'h5BF1);
    run_cmd(16'h6061);
    run_cmd(16'h47F3);
    run_cmd(16'h53F7);
    stray_pulse();
    run_cmd(16'hA123);

    // Random moves with the odd set-position mixed in
    for (int i = 0; i < 12; i++) begin
      op = ($urandom_range(3, 0) == 3) ? OP_MOVE_FANFARE : OP_MOVE;
      if ($urandom_range(4, 0) == 0) begin
        rx = $urandom_range(7, 0);
        ry = $urandom_range(7, 0);
        run_cmd({OP_SET_POS, 5'b0, rx, 1'b0, ry});
      end else begin
        run_cmd({op, dirs[$urandom_range(3, 0)], 4'($urandom_range(5, 0))});
      end
    end

    repeat (2) @(negedge clk);
    if (!timed_out && sent != test_count) begin
      $display("%0d responses checked for %0d commands sent", test_count, sent);
    end
    $display("tests %0d errors %0d", test_count, error_count);
    if (timed_out || error_count != 0 || sent != test_count) begin
      $display("sim failed");
    end else begin
      $display("sim passed");
    end
    $finish;
  end

endmodule
